// File: rtl/adda_pkg.sv
/* Converter-side definitions
 * Sample width, PmodDA2 operating modes and the DAC frame word
 */
package adda_pkg;

	localparam int sample_w = 12;	// Both converters are 12 bit
	localparam int dac_frame_w = 16;

	typedef logic [sample_w-1:0] sample_t;

	// DA2 operating mode bits, sent just ahead of the sample
	typedef enum logic [1:0]
	{
		dac_mode_normal  = 2'd0,
		dac_mode_pd_1k   = 2'd1,	// Output to ground through 1k
		dac_mode_pd_100k = 2'd2,	// Output to ground through 100k
		dac_mode_pd_hiz  = 2'd3
	} dac_mode_e;

	// Field view of one DAC frame, most significant first
	typedef struct packed
	{
		logic [1:0] zero;	// Don't care bits, kept at zero
		dac_mode_e mode;
		sample_t data;
	} dac_fields_t;

	// Built by fields, shifted out as raw bits
	typedef union packed
	{
		logic [dac_frame_w-1:0] raw;
		dac_fields_t f;
	} dac_frame_u;

endpackage

// File: rtl/filt_pkg.sv
/* Signal-processing definitions
 * Sample pair from the ADC and the per-lane filter result
 */
package filt_pkg;

	localparam int n_lanes = 2;	// One lane per ADC channel

	// Both ADC channels of one conversion frame
	typedef struct packed
	{
		adda_pkg::sample_t ch0;
		adda_pkg::sample_t ch1;
	} sample_pair_t;

	// One lane output, valid for a single cycle
	typedef struct packed
	{
		logic valid;
		adda_pkg::sample_t value;
	} lane_out_t;

endpackage

// File: rtl/ad1_reader.sv
/* PmodAD1 reader
 * Runs conversion frames back to back and deserializes both channels
 */
module ad1_reader
	import adda_pkg::*, filt_pkg::*;
#(
	parameter int sck_half = 2,
	parameter int frame_gap = 40
)
(
	input  logic genclk,
	input  logic rst_n,
	input  logic d0,
	input  logic d1,
	output logic cs,
	output logic sck,
	output sample_pair_t pair,
	output logic pair_valid
);

	localparam int div_w = $clog2(sck_half + 1);
	localparam int gap_w = $clog2(frame_gap + 1);

	typedef enum logic [1:0]
	{
		st_gap,
		st_frame,
		st_done
	} state_t;

	state_t state;
	logic [div_w-1:0] div_cnt;
	logic [gap_w-1:0] gap_cnt;
	logic [3:0] bit_cnt;	// Rising edges seen in this frame
	logic div_wrap;
	logic sample_en;
	sample_t shift0;
	sample_t shift1;

	assign div_wrap = (div_cnt == div_w'(sck_half - 1));
	assign sample_en = (state == st_frame) && div_wrap && !sck;	// Next sck edge is rising

	always_ff @(posedge genclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= st_gap;
			cs <= 1'b1;
			sck <= 1'b1;
			div_cnt <= '0;
			gap_cnt <= '0;
			bit_cnt <= '0;
			pair_valid <= 1'b0;
		end
		else
		begin
			pair_valid <= 1'b0;
			case (state)
				st_gap:
				begin
					if (gap_cnt == gap_w'(frame_gap - 1))
					begin
						gap_cnt <= '0;
						cs <= 1'b0;	// Start conversion
						div_cnt <= '0;
						bit_cnt <= '0;
						state <= st_frame;
					end
					else
						gap_cnt <= gap_cnt + 1'b1;
				end
				st_frame:
				begin
					if (div_wrap)
					begin
						div_cnt <= '0;
						sck <= ~sck;
						if (sample_en)
						begin
							bit_cnt <= bit_cnt + 1'b1;
							if (bit_cnt == 4'd15)
							begin
								cs <= 1'b1;	// Last bit taken
								state <= st_done;
							end
						end
					end
					else
						div_cnt <= div_cnt + 1'b1;
				end
				st_done:
				begin
					pair_valid <= 1'b1;
					state <= st_gap;
				end
				default:
					state <= st_gap;
			endcase
		end
	end

	// Leading four bits fall out of the top
	always_ff @(posedge genclk)
	begin
		if (sample_en)
		begin
			shift0 <= {shift0[sample_w-2:0], d0};
			shift1 <= {shift1[sample_w-2:0], d1};
		end
	end

	// Shift registers hold still through the gap
	assign pair = '{ch0: shift0, ch1: shift1};

endmodule

// File: rtl/deriv_lane.sv
/* Three-tap FIR differentiator lane
 * y = 2x(m) - x(m+1)/2 - 3x(m-1)/2 plus DC offset, or raw bypass
 */
module deriv_lane
	import adda_pkg::*, filt_pkg::*;
#(
	parameter int dc_offset = 128
)
(
	input  logic genclk,
	input  logic rst_n,
	input  sample_t sample,
	input  logic sample_valid,
	input  logic bypass,
	output lane_out_t result
);

	sample_t x_next;	// x(m+1)
	sample_t x_cur;	// x(m)
	logic [15:0] two_x;
	logic [15:0] half_new;
	logic [15:0] three_x;
	logic [15:0] y_wide;
	logic res_valid;
	sample_t res_value;

	// Terms taken from the history as it stands after this shift
	always_comb
	begin
		two_x = 16'(x_next) << 1;	// Old x(m+1) becomes x(m)
		half_new = 16'(sample >> 1);
		three_x = 16'(x_cur) + 16'(x_cur) + 16'(x_cur);	// Old x(m) becomes x(m-1)
		y_wide = two_x - half_new - (three_x >> 1) + 16'(dc_offset);
	end

	always_ff @(posedge genclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			x_next <= '0;
			x_cur <= '0;
			res_valid <= 1'b0;
		end
		else
		begin
			res_valid <= sample_valid;
			if (sample_valid && !bypass)	// History frozen in bypass
			begin
				x_cur <= x_next;
				x_next <= sample;
			end
		end
	end

	always_ff @(posedge genclk)
	begin
		if (sample_valid)
			res_value <= bypass ? sample : y_wide[sample_w-1:0];	// Wraps mod 4096
	end

	assign result = '{valid: res_valid, value: res_value};

endmodule

// File: rtl/da2_writer.sv
/* PmodDA2 writer
 * Shifts both lane results out as DAC frames on two data lines at once
 */
module da2_writer
	import adda_pkg::*, filt_pkg::*;
#(
	parameter int sck_half = 2
)
(
	input  logic genclk,
	input  logic rst_n,
	input  lane_out_t res_a,
	input  lane_out_t res_b,
	output logic sync,
	output logic sck,
	output logic din_a,
	output logic din_b
);

	localparam int div_w = $clog2(sck_half + 1);

	typedef enum logic [1:0]
	{
		st_idle,
		st_shift,
		st_end
	} state_t;

	state_t state;
	logic [div_w-1:0] div_cnt;
	logic [4:0] bit_cnt;	// Falling edges seen in this frame
	logic div_wrap;
	logic load;
	logic last_rise;
	logic shift_en;
	dac_frame_u frame_a;
	dac_frame_u frame_b;
	dac_frame_u sh_a;
	dac_frame_u sh_b;

	always_comb
	begin
		frame_a.f.zero = 2'b00;
		frame_a.f.mode = dac_mode_normal;
		frame_a.f.data = res_a.value;
		frame_b.f.zero = 2'b00;
		frame_b.f.mode = dac_mode_normal;
		frame_b.f.data = res_b.value;
	end

	// All lanes pulse together, lane 0 paces the writer
	assign load = (state == st_idle) && res_a.valid;
	assign div_wrap = (div_cnt == div_w'(sck_half - 1));
	assign last_rise = (bit_cnt == 5'd16);
	assign shift_en = (state == st_shift) && div_wrap && !sck && !last_rise;

	always_ff @(posedge genclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= st_idle;
			sync <= 1'b1;
			sck <= 1'b1;
			din_a <= 1'b0;
			din_b <= 1'b0;
			div_cnt <= '0;
			bit_cnt <= '0;
		end
		else
		begin
			case (state)
				st_idle:
				begin
					if (load)
					begin
						sync <= 1'b0;
						din_a <= frame_a.raw[15];	// MSB out with sync
						din_b <= frame_b.raw[15];
						div_cnt <= '0;
						bit_cnt <= '0;
						state <= st_shift;
					end
				end
				st_shift:
				begin
					if (div_wrap)
					begin
						div_cnt <= '0;
						sck <= ~sck;
						if (sck)
							bit_cnt <= bit_cnt + 1'b1;	// DAC samples here
						else if (last_rise)
						begin
							din_a <= 1'b0;
							din_b <= 1'b0;
							state <= st_end;
						end
						else
						begin
							din_a <= sh_a.raw[15];
							din_b <= sh_b.raw[15];
						end
					end
					else
						div_cnt <= div_cnt + 1'b1;
				end
				st_end:
				begin
					sync <= 1'b1;
					state <= st_idle;
				end
				default:
					state <= st_idle;
			endcase
		end
	end

	// Holds the bits still to go, next one on top
	always_ff @(posedge genclk)
	begin
		if (load)
		begin
			sh_a.raw <= {frame_a.raw[14:0], 1'b0};
			sh_b.raw <= {frame_b.raw[14:0], 1'b0};
		end
		else if (shift_en)
		begin
			sh_a.raw <= {sh_a.raw[14:0], 1'b0};
			sh_b.raw <= {sh_b.raw[14:0], 1'b0};
		end
	end

endmodule

// File: rtl/deriv_filter_top.sv
/* Two-channel derivative filter
 * PmodAD1 in, one FIR differentiator lane per channel, PmodDA2 out
 */
module deriv_filter_top
	import adda_pkg::*, filt_pkg::*;
#(
	parameter int sck_half = 2,
	parameter int frame_gap = 40,
	parameter int dc_offset = 128
)
(
	input  logic genclk,
	input  logic rst_n,
	input  logic adc_d0,
	input  logic adc_d1,
	input  logic [1:0] bypass,
	output logic adc_cs,
	output logic adc_sck,
	output logic dac_sync,
	output logic dac_sck,
	output logic dac_din_a,
	output logic dac_din_b
);

	sample_pair_t pair;
	logic pair_valid;
	sample_t lane_in [n_lanes];
	lane_out_t lane_res [n_lanes];

	ad1_reader #(
		.sck_half(sck_half),
		.frame_gap(frame_gap)
	) u_reader (
		.genclk(genclk),
		.rst_n(rst_n),
		.d0(adc_d0),
		.d1(adc_d1),
		.cs(adc_cs),
		.sck(adc_sck),
		.pair(pair),
		.pair_valid(pair_valid)
	);

	assign lane_in[0] = pair.ch0;	// Channel i feeds lane i
	assign lane_in[1] = pair.ch1;

	for (genvar i = 0; i < n_lanes; i++)
	begin : g_lane
		deriv_lane #(
			.dc_offset(dc_offset)
		) u_lane (
			.genclk(genclk),
			.rst_n(rst_n),
			.sample(lane_in[i]),
			.sample_valid(pair_valid),
			.bypass(bypass[i]),
			.result(lane_res[i])
		);
	end

	da2_writer #(
		.sck_half(sck_half)
	) u_writer (
		.genclk(genclk),
		.rst_n(rst_n),
		.res_a(lane_res[0]),
		.res_b(lane_res[1]),
		.sync(dac_sync),
		.sck(dac_sck),
		.din_a(dac_din_a),
		.din_b(dac_din_b)
	);

endmodule

// File: tests/deriv_assert.sv
/* Serial bus checks for the ADC reader and the DAC writer
 * Bound into both, with cs or sync as the frame line
 */
module deriv_assert
(
	input logic genclk,
	input logic rst_n,
	input logic frame_n,	// cs or sync, low during a frame
	input logic sck,
	input logic strobe	// pair_valid or the writer's load request
);

	// A writer load or a new sample pair only comes between frames
	strobe_between_frames: assert property (@(posedge genclk) disable iff (!rst_n)
		strobe |-> frame_n)
		else $error("strobe seen while a serial frame is running");

	// Serial clock stays parked outside a frame
	sck_inside_frame: assert property (@(posedge genclk) disable iff (!rst_n)
		(sck != $past(sck)) |-> !$past(frame_n))
		else $error("sck toggled with the frame line high");

	strobe_single_cycle: assert property (@(posedge genclk) disable iff (!rst_n)
		strobe |=> !strobe)
		else $error("strobe held for more than one cycle");

endmodule

bind ad1_reader deriv_assert u_reader_assert
(
	.genclk(genclk),
	.rst_n(rst_n),
	.frame_n(cs),
	.sck(sck),
	.strobe(pair_valid)
);

bind da2_writer deriv_assert u_writer_assert
(
	.genclk(genclk),
	.rst_n(rst_n),
	.frame_n(sync),
	.sck(sck),
	.strobe(res_a.valid)
);

// File: tests/deriv_tb.sv
/* Derivative filter testbench
 * Random ADC frames in, DAC frames checked against a lane model
 */
module deriv_tb
	import adda_pkg::*;
();

	localparam int n_frames = 300;
	localparam int frame_timeout = 1000;	// Cycles allowed per DAC frame
	localparam int dc_offset = 128;
	localparam int bypass_delay = 8;	// Gap cycles before bypass moves

	logic genclk;
	logic rst_n;
	logic adc_d0;
	logic adc_d1;
	logic [1:0] bypass;
	logic adc_cs;
	logic adc_sck;
	logic dac_sync;
	logic dac_sck;
	logic dac_din_a;
	logic dac_din_b;

	// Lane model history, x(m+1), x(m), x(m-1)
	int hist_next [2] = '{0, 0};
	int hist_cur [2] = '{0, 0};
	int hist_prev [2] = '{0, 0};
	sample_t exp_q0 [$];
	sample_t exp_q1 [$];

	logic [15:0] adc_word0 = '0;
	logic [15:0] adc_word1 = '0;
	int adc_bits = 0;
	int gap_cnt = 0;
	logic prev_adc_cs = 1'b1;
	logic prev_adc_sck = 1'b1;
	dac_frame_u dac_rx_a = '0;
	dac_frame_u dac_rx_b = '0;
	int dac_bits = 0;
	int dac_frames = 0;
	logic prev_dac_sck = 1'b1;
	logic prev_dac_sync = 1'b1;

	deriv_filter_top uut
	(
		.genclk(genclk),
		.rst_n(rst_n),
		.adc_d0(adc_d0),
		.adc_d1(adc_d1),
		.bypass(bypass),
		.adc_cs(adc_cs),
		.adc_sck(adc_sck),
		.dac_sync(dac_sync),
		.dac_sck(dac_sck),
		.dac_din_a(dac_din_a),
		.dac_din_b(dac_din_b)
	);

	always #50 genclk = ~genclk;

	task automatic abort_run();
		$display("TESTBENCH FAILED");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	task automatic report_problem(input string what);
		$display("Failure at %0t: %s", $time, what);
		abort_run();
	endtask

	task automatic expect_level(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("Error at %0t: %s got %b expected %b", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic compare_sample(input string name, input sample_t got, input sample_t exp);
		if (got !== exp)
		begin
			$display("Error at %0t: %s got %0d expected %0d", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_mode(input string name, input dac_mode_e got, input dac_mode_e exp);
		if (got !== exp)
		begin
			$display("Error at %0t: %s got %0d expected %0d", $time, name, got, exp);
			abort_run();
		end
	endtask

	// Shift first, then y = 2x(m) - x(m+1)/2 - 3x(m-1)/2 + offset, wrapped to 12 bits
	function automatic sample_t model_lane(input logic lane, input sample_t s, input logic byp);
		int y;
		if (byp)
			return s;	// History frozen
		hist_prev[lane] = hist_cur[lane];
		hist_cur[lane] = hist_next[lane];
		hist_next[lane] = int'(s);
		y = 2 * hist_cur[lane] - hist_next[lane] / 2 - (3 * hist_prev[lane]) / 2 + dc_offset;
		return sample_t'(y);
	endfunction

	task automatic score_dac_frame(input dac_frame_u fa, input dac_frame_u fb);
		sample_t exp_a;
		sample_t exp_b;
		if (exp_q0.size() == 0 || exp_q1.size() == 0)
			report_problem("DAC frame arrived with no ADC frame behind it");
		else
		begin
			exp_a = exp_q0.pop_front();
			exp_b = exp_q1.pop_front();
			expect_level("dac_din_a lead bit 15", fa.f.zero[1], 1'b0);
			expect_level("dac_din_a lead bit 14", fa.f.zero[0], 1'b0);
			expect_level("dac_din_b lead bit 15", fb.f.zero[1], 1'b0);
			expect_level("dac_din_b lead bit 14", fb.f.zero[0], 1'b0);
			check_mode("dac_din_a mode", fa.f.mode, dac_mode_normal);
			check_mode("dac_din_b mode", fb.f.mode, dac_mode_normal);
			compare_sample("dac_din_a data", fa.f.data, exp_a);
			compare_sample("dac_din_b data", fb.f.data, exp_b);
			if (exp_q0.size() > 1)
				report_problem("ADC frames are running ahead of DAC frames");
			dac_frames <= dac_frames + 1;
		end
	endtask

	// PmodAD1 model, next bit after each sck fall
	always @(posedge genclk)
	begin : adc_model
		sample_t s0;
		sample_t s1;
		prev_adc_cs <= adc_cs;
		prev_adc_sck <= adc_sck;
		if (rst_n && prev_adc_cs && !adc_cs)	// Frame start
		begin
			adc_word0 = 16'($urandom);
			adc_word1 = 16'($urandom);
			adc_bits = 0;
			s0 = adc_word0[11:0];
			s1 = adc_word1[11:0];
			exp_q0.push_back(model_lane(1'b0, s0, bypass[0]));
			exp_q1.push_back(model_lane(1'b1, s1, bypass[1]));
		end
		if (rst_n && !adc_cs && prev_adc_sck && !adc_sck)
		begin
			if (adc_bits >= 16)
				report_problem("ADC frame ran past 16 sck falls");
			adc_d0 <= adc_word0[15];
			adc_d1 <= adc_word1[15];
			adc_word0 = adc_word0 << 1;
			adc_word1 = adc_word1 << 1;
			adc_bits++;
		end
		if (rst_n && !prev_adc_cs && adc_cs)
		begin
			if (adc_bits != 16)
				report_problem($sformatf("ADC frame ended after %0d bits", adc_bits));
			gap_cnt = 1;
		end
		else if (gap_cnt > 0)
		begin
			gap_cnt++;
			if (gap_cnt == bypass_delay)	// Well after pair_valid
			begin
				bypass <= {($urandom % 4 == 0), ($urandom % 4 == 0)};
				gap_cnt = 0;
			end
		end
	end

	// PmodDA2 model, takes din on sck falls
	always @(posedge genclk)
	begin
		prev_dac_sck <= dac_sck;
		prev_dac_sync <= dac_sync;
		if (rst_n && !dac_sync && prev_dac_sck && !dac_sck)
		begin
			if (dac_bits >= 16)
				report_problem("DAC frame ran past 16 sck falls");
			dac_rx_a.raw = {dac_rx_a.raw[14:0], dac_din_a};
			dac_rx_b.raw = {dac_rx_b.raw[14:0], dac_din_b};
			dac_bits++;
			if (dac_bits == 16)
				score_dac_frame(dac_rx_a, dac_rx_b);
		end
		if (rst_n && !prev_dac_sync && dac_sync)
		begin
			if (dac_bits != 16)
				report_problem($sformatf("DAC sync rose after %0d bits", dac_bits));
			dac_bits = 0;
		end
	end

	initial
	begin
		int waited;
		int seen;
		genclk = 1'b0;
		rst_n = 1'b0;
		adc_d0 = 1'b0;
		adc_d1 = 1'b0;
		bypass = 2'b00;
		void'($urandom(32'h657a_97ee));
		repeat (5) @(posedge genclk);
		expect_level("adc_cs", adc_cs, 1'b1);
		expect_level("adc_sck", adc_sck, 1'b1);
		expect_level("dac_sync", dac_sync, 1'b1);
		expect_level("dac_sck", dac_sck, 1'b1);
		expect_level("dac_din_a", dac_din_a, 1'b0);
		expect_level("dac_din_b", dac_din_b, 1'b0);
		expect_level("pair_valid", uut.u_reader.pair_valid, 1'b0);
		rst_n <= 1'b1;
		for (int f = 0; f < n_frames; f++)
		begin
			seen = dac_frames;
			waited = 0;
			while (dac_frames == seen)
			begin
				@(posedge genclk);
				waited++;
				if (waited > frame_timeout)
					report_problem($sformatf("timed out waiting for DAC frame %0d", f));
			end
		end
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// File: list.f
rtl/adda_pkg.sv
rtl/filt_pkg.sv
rtl/ad1_reader.sv
rtl/deriv_lane.sv
rtl/da2_writer.sv
rtl/deriv_filter_top.sv
tests/deriv_assert.sv
tests/deriv_tb.sv

// File: run.sh
#!/bin/sh
# Build the derivative filter testbench with Verilator and run it.
# The exit status is the simulator's: nonzero on any fatal check.
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert --top-module deriv_tb -f list.f -o deriv_sim \
	&& ./obj_dir/deriv_sim \
	|| exit 1
